/* hdl/spi_cfg_pkg.sv */
package spi_cfg_pkg;

    // SPI mode, mode 0 as built
    localparam logic cpol = 1'b0;  // SCLK level while idle
    localparam logic cpha = 1'b0;  // Sample on leading edge when clear

    // Clk cycles per SCLK half period
    // Must stay at or above 1
    localparam int sclk_half = 2;

    localparam int byte_bits = 8;  // Bits per transfer

    // Counter sizing for the shift engine
    localparam int half_cnt_w = (sclk_half > 1) ? $clog2(sclk_half) : 1;
    localparam int edge_cnt_w = $clog2(2 * byte_bits);

    // Terminal count of one half period
    localparam logic [half_cnt_w-1:0] half_last = half_cnt_w'(sclk_half - 1);

    // Index of the final SCLK edge of a byte
    localparam logic [edge_cnt_w-1:0] last_edge = edge_cnt_w'(2 * byte_bits - 1);

    // Final sampling edge, one later with phase 1
    localparam logic [edge_cnt_w-1:0] last_sample =
        edge_cnt_w'(2 * byte_bits - 2 + int'(cpha));

endpackage

/* hdl/spi_xfer_pkg.sv */
package spi_xfer_pkg;

    // One SPI data word, MSB goes out first
    typedef logic [spi_cfg_pkg::byte_bits-1:0] spi_byte_t;

    // Command as it travels from the host link to the shift engine
    typedef struct packed {
        spi_byte_t tx_byte;  // Byte to send on MOSI
        logic      hold;     // Keep chip select low after this byte
    } spi_cmd_t;

endpackage

/* hdl/hs_slice.sv */
`timescale 1ns/10ps

module hs_slice #(
    parameter type payload_t = spi_xfer_pkg::spi_byte_t
) (
    input  logic     clk,
    input  logic     rst,
    // Upstream four-phase link
    input  logic     in_req,
    output logic     in_ack,
    input  payload_t in_data,
    // Downstream four-phase link
    output logic     out_req,
    input  logic     out_ack,
    output payload_t out_data
);

    // Sender side of the slice
    typedef enum logic [1:0] {
        sl_empty,   // No payload held
        sl_req,     // Payload offered downstream
        sl_drain    // Waiting for out_ack to return low
    } slice_state_t;

    slice_state_t state;
    payload_t     data_q;
    logic         capture;

    // New payload only when empty and the previous input handshake has closed
    assign capture = (state == sl_empty) && in_req && !in_ack;

    // Receiver side, ack right after capture
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack <= 1'b0;
        end else if (capture) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0;  // Sender has dropped req
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sl_empty;
        end else begin
            case (state)
                sl_empty: begin
                    if (capture) begin
                        state <= sl_req;
                    end
                end
                sl_req: begin
                    if (out_ack) begin
                        state <= sl_drain;
                    end
                end
                sl_drain: begin
                    if (!out_ack) begin
                        state <= sl_empty;
                    end
                end
                default: begin
                    state <= sl_empty;
                end
            endcase
        end
    end

    // Holding register
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= in_data;
        end
    end

    assign out_req  = (state == sl_req);
    assign out_data = data_q;  // Stable from capture until the slice empties

endmodule

/* hdl/spi_shift_engine.sv */
`timescale 1ns/10ps

module spi_shift_engine (
    input  logic                    clk,
    input  logic                    rst,
    // Command link, engine is the receiver
    input  logic                    in_req,
    output logic                    in_ack,
    input  spi_xfer_pkg::spi_cmd_t  in_cmd,
    // Result link, engine is the sender
    output logic                    out_req,
    input  logic                    out_ack,
    output spi_xfer_pkg::spi_byte_t out_byte,
    // SPI pins
    output logic                    sclk,
    output logic                    mosi,
    input  logic                    miso,
    output logic                    cs_n
);

    typedef enum logic [2:0] {
        st_idle,     // Ready for a command
        st_lead,     // Chip select setup, first half period
        st_shift,    // Remaining SCLK edges
        st_trail,    // Chip select hold after the last edge
        st_deliver   // Wait for the result handshake to close
    } eng_state_t;

    eng_state_t                         state;
    logic [spi_cfg_pkg::half_cnt_w-1:0] half_cnt;   // Clk cycles within a half period
    logic [spi_cfg_pkg::edge_cnt_w-1:0] edge_cnt;   // SCLK edges done in this byte
    spi_xfer_pkg::spi_byte_t            shreg;      // TX bits out the top, RX bits in below
    logic                               hold_q;
    logic                               take_cmd;
    logic                               half_done;
    logic                               edge_now;
    logic                               sample_now;
    logic                               rx_done;
    logic                               ack_wait;

    assign take_cmd  = (state == st_idle) && in_req && !in_ack;
    assign half_done = (half_cnt == spi_cfg_pkg::half_last);

    // An SCLK edge falls at the end of every half period from lead on
    assign edge_now = ((state == st_lead) || (state == st_shift)) && half_done;

    // Even edges lead, odd edges trail
    assign sample_now = edge_now && (edge_cnt[0] == spi_cfg_pkg::cpha);

    // Command handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack <= 1'b0;
        end else if (take_cmd) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0;
        end
    end

    // Main sequencer, SCLK, chip select and MOSI
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            half_cnt <= '0;
            edge_cnt <= '0;
            hold_q   <= 1'b0;
            sclk     <= spi_cfg_pkg::cpol;
            cs_n     <= 1'b1;
            mosi     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (take_cmd) begin
                        hold_q   <= in_cmd.hold;
                        cs_n     <= 1'b0;  // No change inside a hold run
                        half_cnt <= '0;
                        edge_cnt <= '0;
                        state    <= st_lead;
                        // Phase 0 wants the MSB out before the first edge
                        if (!spi_cfg_pkg::cpha) begin
                            mosi <= in_cmd.tx_byte[spi_cfg_pkg::byte_bits-1];
                        end
                    end
                end
                st_lead, st_shift: begin
                    if (half_done) begin
                        half_cnt <= '0;
                        sclk     <= ~sclk;
                        edge_cnt <= edge_cnt + 1'b1;
                        // Launch on the non-sampling edges, none after the last one
                        if (!sample_now && (edge_cnt != spi_cfg_pkg::last_edge)) begin
                            mosi <= shreg[spi_cfg_pkg::byte_bits-1];
                        end
                        if (edge_cnt == spi_cfg_pkg::last_edge) begin
                            state <= st_trail;  // SCLK back at idle level
                        end else begin
                            state <= st_shift;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                st_trail: begin
                    if (half_done) begin
                        half_cnt <= '0;
                        if (!hold_q) begin
                            cs_n <= 1'b1;  // End of frame
                        end
                        state <= st_deliver;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                st_deliver: begin
                    // Next command only once the result is handed off
                    if (!rx_done && !out_req && !ack_wait) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Shift register, loaded with the TX byte and filled from MISO
    always_ff @(posedge clk) begin
        if (take_cmd) begin
            shreg <= in_cmd.tx_byte;
        end else if (sample_now) begin
            shreg <= {shreg[spi_cfg_pkg::byte_bits-2:0], miso};
        end
    end

    // Result handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_done  <= 1'b0;
            out_req  <= 1'b0;
            ack_wait <= 1'b0;
        end else begin
            // Pulse on the final sampling edge
            rx_done <= sample_now && (edge_cnt == spi_cfg_pkg::last_sample);
            if (rx_done) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req  <= 1'b0;
                ack_wait <= 1'b1;
            end else if (ack_wait && !out_ack) begin
                ack_wait <= 1'b0;  // Handshake closed
            end
        end
    end

    // Shift register holds still until the next command is taken
    assign out_byte = shreg;

endmodule

/* hdl/spi_master_top.sv */
`timescale 1ns/10ps

module spi_master_top (
    input  logic       clk,
    input  logic       rst,
    // Host command link
    input  logic       cmd_req,
    output logic       cmd_ack,
    input  logic [7:0] cmd_data,
    input  logic       cmd_hold,
    // Host response link
    output logic       rsp_req,
    input  logic       rsp_ack,
    output logic [7:0] rsp_data,
    // SPI bus
    output logic       spi_sclk,
    output logic       spi_mosi,
    output logic       spi_cs_n,
    input  logic       spi_miso
);

    // Host command packed for the pipeline
    spi_xfer_pkg::spi_cmd_t  host_cmd;

    // Command slice to engine
    spi_xfer_pkg::spi_cmd_t  eng_cmd;
    logic                    eng_cmd_req;
    logic                    eng_cmd_ack;

    // Engine to response slice
    spi_xfer_pkg::spi_byte_t eng_rsp;
    logic                    eng_rsp_req;
    logic                    eng_rsp_ack;

    assign host_cmd.tx_byte = cmd_data;
    assign host_cmd.hold    = cmd_hold;

    hs_slice #(
        .payload_t (spi_xfer_pkg::spi_cmd_t)
    ) cmd_slice (
        .clk      (clk),
        .rst      (rst),
        .in_req   (cmd_req),
        .in_ack   (cmd_ack),
        .in_data  (host_cmd),
        .out_req  (eng_cmd_req),
        .out_ack  (eng_cmd_ack),
        .out_data (eng_cmd)
    );

    spi_shift_engine shift_engine (
        .clk      (clk),
        .rst      (rst),
        .in_req   (eng_cmd_req),
        .in_ack   (eng_cmd_ack),
        .in_cmd   (eng_cmd),
        .out_req  (eng_rsp_req),
        .out_ack  (eng_rsp_ack),
        .out_byte (eng_rsp),
        .sclk     (spi_sclk),
        .mosi     (spi_mosi),
        .miso     (spi_miso),
        .cs_n     (spi_cs_n)
    );

    // Received bytes wait here for the host
    hs_slice #(
        .payload_t (spi_xfer_pkg::spi_byte_t)
    ) rsp_slice (
        .clk      (clk),
        .rst      (rst),
        .in_req   (eng_rsp_req),
        .in_ack   (eng_rsp_ack),
        .in_data  (eng_rsp),
        .out_req  (rsp_req),
        .out_ack  (rsp_ack),
        .out_data (rsp_data)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Release a little after the edge so the DUT sees a clean deassertion
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* verif/spi_master_assert.sv */
`timescale 1ns/10ps

module spi_master_assert (
    input logic       clk,
    input logic       rst,
    input logic       cmd_req,
    input logic [7:0] cmd_data,
    input logic       cmd_hold,
    input logic       rsp_req,
    input logic       rsp_ack,
    input logic [7:0] rsp_data,
    input logic       spi_sclk,
    input logic       spi_cs_n
);

    // Host must hold the command steady until it is acknowledged
    cmd_payload_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_req && $past(cmd_req) |-> $stable(cmd_data) && $stable(cmd_hold))
        else $error("Command payload changed while cmd_req was high");

    rsp_req_held: assert property (@(posedge clk) disable iff (rst)
        rsp_req && !rsp_ack |=> rsp_req)
        else $error("rsp_req fell before rsp_ack rose");

    rsp_payload_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_req && $past(rsp_req) |-> $stable(rsp_data))
        else $error("rsp_data changed while rsp_req was high");

    // No clock activity outside a frame
    sclk_idle: assert property (@(posedge clk) disable iff (rst)
        spi_cs_n |-> (spi_sclk == spi_cfg_pkg::cpol))
        else $error("spi_sclk away from idle level with chip select high");

endmodule

bind spi_master_top spi_master_assert protocol_checks (
    .clk(clk), .rst(rst), .cmd_req(cmd_req), .cmd_data(cmd_data), .cmd_hold(cmd_hold),
    .rsp_req(rsp_req), .rsp_ack(rsp_ack), .rsp_data(rsp_data),
    .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n)
);

/* verif/spi_master_tb.sv */
`timescale 1ns/10ps

module spi_master_tb;

    localparam int n_rows      = 10;
    localparam int drive_delay = 1;   // ns after the rising edge
    localparam int bits        = spi_cfg_pkg::byte_bits;

    typedef struct {
        spi_xfer_pkg::spi_byte_t tx;
        logic                    hold;
        spi_xfer_pkg::spi_byte_t rsp;
        int                      delay;  // -1 draws a random delay
    } row_t;

    // tx byte, hold, slave response, response ack delay
    row_t rows [n_rows] = '{
        '{8'ha5, 1'b0, 8'h3c, 0},
        '{8'h01, 1'b1, 8'h80, 2},
        '{8'h7e, 1'b1, 8'hff, -1},
        '{8'hc3, 1'b0, 8'h00, 1},
        '{8'hff, 1'b0, 8'h5a, 60},   // Long stall to fill the pipeline
        '{8'h00, 1'b0, 8'hc0, 0},
        '{8'h96, 1'b1, 8'h69, -1},
        '{8'h3b, 1'b0, 8'hb4, 45},
        '{8'he1, 1'b0, 8'h1e, -1},
        '{8'h55, 1'b1, 8'haa, 3}
    };

    logic clk, rst;
    logic cmd_req, cmd_ack, cmd_hold;
    logic rsp_req, rsp_ack;
    logic [7:0] cmd_data, rsp_data;
    logic spi_sclk, spi_mosi, spi_cs_n, spi_miso;

    int acked_cnt = 0;
    int rsp_cnt = 0;
    int limit_cycles = 0;
    int frame_cnt = 0;
    int slave_idx = 0;
    int bit_cnt = 0;
    spi_xfer_pkg::spi_byte_t rx_shift;
    spi_xfer_pkg::spi_byte_t cur_byte;
    logic leading;

    tb_clock_gen #(.period_ns(100), .reset_cycles(16)) clock_src (.clk(clk), .rst(rst));

    spi_master_top UUT (
        .clk(clk), .rst(rst),
        .cmd_req(cmd_req), .cmd_ack(cmd_ack), .cmd_data(cmd_data), .cmd_hold(cmd_hold),
        .rsp_req(rsp_req), .rsp_ack(rsp_ack), .rsp_data(rsp_data),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n), .spi_miso(spi_miso)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("[FAIL] %s expected 0x%0h got 0x%0h",
                                     name, expected, actual));
    endtask

    task automatic check_idle_outputs();
        check_value("cmd_ack", 1'b0, cmd_ack);
        check_value("rsp_req", 1'b0, rsp_req);
        check_value("spi_cs_n", 1'b1, spi_cs_n);
        check_value("spi_sclk", spi_cfg_pkg::cpol, spi_sclk);
    endtask

    // Frames expected from the hold flags of the table
    function automatic int count_frames();
        int n;
        n = 0;
        for (int i = 0; i < n_rows; i++) begin
            if (i == 0 || !rows[i-1].hold) n++;
        end
        return n;
    endfunction

    task automatic drive_commands();
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #drive_delay;
            cmd_data = rows[i].tx;
            cmd_hold = rows[i].hold;
            cmd_req  = 1'b1;
            do begin
                @(posedge clk);
                #drive_delay;
            end while (cmd_ack !== 1'b1);
            acked_cnt++;
            // Two slices and the engine hold one byte each
            assert (acked_cnt - rsp_cnt <= 3)
                else abort_run("More than three commands were acknowledged ahead of responses");
            cmd_req = 1'b0;
            do begin
                @(posedge clk);
                #drive_delay;
            end while (cmd_ack !== 1'b0);
        end
    endtask

    task automatic accept_responses();
        for (int i = 0; i < n_rows; i++) begin
            do begin
                @(posedge clk);
                #drive_delay;
            end while (rsp_req !== 1'b1);
            check_value("rsp_data", rows[i].rsp, rsp_data);
            repeat (rows[i].delay) begin
                @(posedge clk);
                #drive_delay;
            end
            rsp_ack = 1'b1;
            rsp_cnt++;
            do begin
                @(posedge clk);
                #drive_delay;
            end while (rsp_req !== 1'b0);
            rsp_ack = 1'b0;
        end
    endtask

    // SPI slave model starts a new frame
    always @(negedge spi_cs_n) begin
        if (rst === 1'b0) begin
            assert (slave_idx < n_rows)
                else abort_run("Chip select fell with no command left in the table");
            frame_cnt++;
            bit_cnt  = 0;
            cur_byte = rows[slave_idx].rsp;
            if (!spi_cfg_pkg::cpha) spi_miso <= #drive_delay cur_byte[bits-1];  // MSB ahead of first edge
        end
    end

    always @(posedge spi_cs_n) begin
        if (rst === 1'b0 && slave_idx > 0) begin
            assert (!rows[slave_idx-1].hold && bit_cnt == 0)
                else abort_run("Chip select rose inside a hold run or mid byte");
        end
    end

    always @(spi_sclk) begin
        if (spi_cs_n === 1'b0 && rst === 1'b0) begin
            leading = (spi_sclk !== spi_cfg_pkg::cpol);
            if (leading == !spi_cfg_pkg::cpha) begin
                rx_shift = {rx_shift[bits-2:0], spi_mosi};
                bit_cnt++;
                if (bit_cnt == bits) begin
                    check_value("spi_mosi byte", rows[slave_idx].tx, rx_shift);
                    slave_idx++;
                    bit_cnt  = 0;
                    cur_byte = (slave_idx < n_rows) ? rows[slave_idx].rsp : '0;  // Hold run
                end
            end else begin
                spi_miso <= #drive_delay cur_byte[bits-1-bit_cnt];
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run("Timeout, the transfers did not finish in time");
    end

    initial begin
        int max_delay;
        cmd_req  = 1'b0;
        cmd_data = '0;
        cmd_hold = 1'b0;
        rsp_ack  = 1'b0;
        spi_miso = 1'b0;
        void'($urandom(32'hb8f12c1e));
        max_delay = 0;
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].delay < 0) rows[i].delay = $urandom_range(31);
            if (rows[i].delay > max_delay) max_delay = rows[i].delay;
        end
        limit_cycles = n_rows * (bits * 2 * spi_cfg_pkg::sclk_half + max_delay + 40) + 40;

        repeat (4) @(posedge clk);
        #drive_delay;
        check_idle_outputs();  // Still in reset
        wait (rst === 1'b0);
        @(posedge clk);
        #drive_delay;
        check_idle_outputs();

        fork
            drive_commands();
            accept_responses();
        join

        check_value("slave byte count", n_rows, slave_idx);
        check_value("frame count", count_frames(), frame_cnt);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* spi_master_top.f */
hdl/spi_cfg_pkg.sv
hdl/spi_xfer_pkg.sv
hdl/hs_slice.sv
hdl/spi_shift_engine.sv
hdl/spi_master_top.sv
verif/tb_clock_gen.sv
verif/spi_master_assert.sv
verif/spi_master_tb.sv
